// ==== hw/rtcPkg.sv ====
package rtcPkg;

  localparam int NumFields = 9;

  typedef logic [7:0] dataT;
  typedef logic [7:0] busAddrT;
  typedef logic [3:0] cursorT;

  // Fields in RTC read order
  typedef enum logic [3:0] {
    secField,
    minField,
    hourField,
    dayField,
    monthField,
    yearField,
    tSecField,
    tMinField,
    tHourField
  } fieldIdxT;

  typedef dataT [NumFields-1:0] fieldArrayT;

  typedef enum logic [1:0] {
    noGroup,
    timeGroup,
    dateGroup,
    timerGroup
  } editGroupT;

  // ******************************
  // Per-field tables, indexed by fieldIdxT
  // ******************************
  localparam busAddrT RtcAddr [NumFields] = '{
    8'h21, 8'h22, 8'h23, 8'h24, 8'h25, 8'h26, 8'h41, 8'h42, 8'h43
  };

  localparam busAddrT DispAddr [NumFields] = '{
    8'h07, 8'h06, 8'h05, 8'h08, 8'h09, 8'h0A, 8'h0D, 8'h0C, 8'h0B
  };

  localparam dataT FieldMin [NumFields] = '{
    8'd0, 8'd0, 8'd0, 8'd1, 8'd1, 8'd0, 8'd0, 8'd0, 8'd0
  };

  localparam dataT FieldMax [NumFields] = '{
    8'd59, 8'd59, 8'd23, 8'd31, 8'd12, 8'd99, 8'd59, 8'd59, 8'd23
  };

  // Date 0..2, time 3..5, timer 6..8
  localparam cursorT CursorOf [NumFields] = '{
    4'd5, 4'd4, 4'd3, 4'd0, 4'd1, 4'd2, 4'd8, 4'd7, 4'd6
  };

endpackage

// ==== hw/fieldIf.sv ====
`timescale 1ns/10ps

interface fieldIf;
  import rtcPkg::*;

  logic     valid;
  fieldIdxT field;
  dataT     value;
  // One pulse per slot freed by the receiver
  logic     credit;

  modport sender (
    output valid, field, value,
    input  credit
  );

  modport receiver (
    input  valid, field, value,
    output credit
  );

endinterface

// ==== hw/buttonDebouncer.sv ====
`timescale 1ns/10ps

module buttonDebouncer #(
  parameter int DebounceCycles = 16
) (
  input  logic clk,
  input  logic rst,
  input  logic button,
  output logic press
);

  localparam int CountW = $clog2(DebounceCycles + 1);

  logic [1:0]        syncQ;
  logic              stable;
  logic [CountW-1:0] cnt;

  always_ff @(posedge clk) begin
    if (rst) begin
      syncQ  <= 2'b00;
      stable <= 1'b0;
      cnt    <= '0;
      press  <= 1'b0;
    end else begin
      syncQ <= {syncQ[0], button};
      press <= 1'b0;
      if (syncQ[1] == stable) begin
        cnt <= '0;
      end else if (cnt == CountW'(DebounceCycles - 1)) begin
        // Level held long enough, accept it
        stable <= syncQ[1];
        cnt    <= '0;
        press  <= syncQ[1];
      end else begin
        cnt <= cnt + 1'b1;
      end
    end
  end

endmodule

// ==== hw/fieldEditor.sv ====
`timescale 1ns/10ps

module fieldEditor (
  input  logic               clk,
  input  logic               rst,
  input  rtcPkg::editGroupT  editGroup,
  input  logic               editEnable,
  input  rtcPkg::fieldArrayT fields,
  input  logic               upPress,
  input  logic               downPress,
  input  logic               leftPress,
  input  logic               rightPress,
  output logic               editValid,
  output rtcPkg::fieldIdxT   editField,
  output rtcPkg::dataT       editValue,
  output rtcPkg::cursorT     cursorPos
);
  import rtcPkg::*;

  logic [1:0] cursor;
  editGroupT  lastGroup;
  fieldIdxT   selField;
  dataT       curValue;
  dataT       nextValue;
  logic       doEdit;

  // Field under the cursor, date order when no group is active
  always_comb begin
    case (editGroup)
      timeGroup: begin
        selField = (cursor == 2'd0) ? hourField : (cursor == 2'd1) ? minField : secField;
      end
      timerGroup: begin
        selField = (cursor == 2'd0) ? tHourField : (cursor == 2'd1) ? tMinField : tSecField;
      end
      default: begin
        selField = (cursor == 2'd0) ? dayField : (cursor == 2'd1) ? monthField : yearField;
      end
    endcase
  end

  assign cursorPos = CursorOf[selField];
  assign curValue  = fields[selField];
  assign doEdit    = editEnable & (upPress | downPress);

  // Wrapped step, up wins over down
  always_comb begin
    if (upPress) begin
      nextValue = (curValue >= FieldMax[selField]) ? FieldMin[selField] : curValue + 8'd1;
    end else begin
      nextValue = (curValue <= FieldMin[selField]) ? FieldMax[selField] : curValue - 8'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      cursor    <= 2'd0;
      lastGroup <= noGroup;
      editValid <= 1'b0;
    end else begin
      lastGroup <= editGroup;
      editValid <= doEdit;
      if (editGroup != lastGroup) begin
        cursor <= 2'd0;
      end else if (editEnable && rightPress) begin
        cursor <= (cursor == 2'd2) ? 2'd0 : cursor + 2'd1;
      end else if (editEnable && leftPress) begin
        cursor <= (cursor == 2'd0) ? 2'd2 : cursor - 2'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (doEdit) begin
      editField <= selField;
      editValue <= nextValue;
    end
  end

endmodule

// ==== hw/rtcSequencer.sv ====
`timescale 1ns/10ps

module rtcSequencer #(
  parameter int FifoDepth = 4
) (
  input  logic               clk,
  input  logic               rst,
  input  rtcPkg::dataT       busRdData,
  input  logic               busRdValid,
  input  logic               setTime,
  input  logic               setDate,
  input  logic               setTimer,
  input  logic               editValid,
  input  rtcPkg::fieldIdxT   editField,
  input  rtcPkg::dataT       editValue,
  output rtcPkg::busAddrT    busAddr,
  output logic               busRdEn,
  output logic               busWrEn,
  output rtcPkg::dataT       busWrData,
  output rtcPkg::editGroupT  editGroup,
  output logic               editEnable,
  output rtcPkg::fieldArrayT fields,
  fieldIf.sender             upd
);
  import rtcPkg::*;

  localparam int CreditW = $clog2(FifoDepth + 1);

  typedef enum logic [2:0] {
    readIssue,
    readWait,
    readSend,
    edit,
    writeBack
  } stateT;

  stateT              state;
  fieldIdxT           fieldIdx;
  fieldIdxT           nextIdx;
  fieldArrayT         bank;
  logic [CreditW-1:0] credits;
  logic               anySwitch;
  logic               send;

  assign anySwitch  = setTime | setDate | setTimer;
  assign nextIdx    = (fieldIdx == tHourField) ? secField : fieldIdxT'(fieldIdx + 4'd1);
  assign fields     = bank;
  assign editEnable = (state == edit) && (credits != '0) && anySwitch;

  // ******************************
  // Update link towards the FIFO
  // ******************************
  assign send      = ((state == readSend) && (credits != '0)) || ((state == edit) && editValid);
  assign upd.valid = send;
  assign upd.field = (state == edit) ? editField : fieldIdx;
  assign upd.value = (state == edit) ? editValue : bank[fieldIdx];

  always_ff @(posedge clk) begin
    if (rst) begin
      credits <= CreditW'(FifoDepth);
    end else begin
      credits <= credits - CreditW'(send) + CreditW'(upd.credit);
    end
  end

  // ******************************
  // Main FSM
  // ******************************
  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= readIssue;
      fieldIdx  <= secField;
      busAddr   <= '0;
      busRdEn   <= 1'b0;
      busWrEn   <= 1'b0;
      editGroup <= noGroup;
    end else begin
      busRdEn <= 1'b0;
      busWrEn <= 1'b0;
      case (state)
        readIssue: begin
          busRdEn <= 1'b1;
          busAddr <= RtcAddr[fieldIdx];
          state   <= readWait;
        end
        readWait: begin
          if (busRdValid) begin
            state <= readSend;
          end
        end
        readSend: begin
          if (send) begin
            fieldIdx <= nextIdx;
            // Switch priority is time, date, timer
            if (setTime) begin
              state     <= edit;
              editGroup <= timeGroup;
            end else if (setDate) begin
              state     <= edit;
              editGroup <= dateGroup;
            end else if (setTimer) begin
              state     <= edit;
              editGroup <= timerGroup;
            end else begin
              busRdEn <= 1'b1;
              busAddr <= RtcAddr[nextIdx];
              state   <= readWait;
            end
          end
        end
        edit: begin
          // A pending edit result is taken before leaving
          if (!editValid && !anySwitch) begin
            state     <= writeBack;
            fieldIdx  <= secField;
            editGroup <= noGroup;
          end
        end
        writeBack: begin
          busWrEn  <= 1'b1;
          busAddr  <= RtcAddr[fieldIdx];
          fieldIdx <= nextIdx;
          if (fieldIdx == tHourField) begin
            state <= readIssue;
          end
        end
        default: state <= readIssue;
      endcase
    end
  end

  // Field bank and write data
  always_ff @(posedge clk) begin
    if (state == readWait && busRdValid) begin
      bank[fieldIdx] <= busRdData;
    end else if (state == edit && editValid) begin
      bank[editField] <= editValue;
    end
    if (state == writeBack) begin
      busWrData <= bank[fieldIdx];
    end
  end

endmodule

// ==== hw/updateFifo.sv ====
`timescale 1ns/10ps

module updateFifo #(
  parameter int FifoDepth = 4
) (
  input  logic     clk,
  input  logic     rst,
  fieldIf.receiver src,
  fieldIf.sender   dst
);
  import rtcPkg::*;

  localparam int PtrW   = (FifoDepth > 1) ? $clog2(FifoDepth) : 1;
  localparam int CountW = $clog2(FifoDepth + 1);

  fieldIdxT          fieldMem [FifoDepth];
  dataT              valueMem [FifoDepth];
  logic [PtrW-1:0]   wrPtr;
  logic [PtrW-1:0]   rdPtr;
  logic [CountW-1:0] count;
  logic              dstCredit;
  logic              push;
  logic              pop;

  function automatic logic [PtrW-1:0] incPtr(input logic [PtrW-1:0] ptr);
    if (ptr == PtrW'(FifoDepth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // Upstream only sends with a credit, so no full check
  assign push = src.valid;
  assign pop  = (count != '0) && dstCredit;

  assign dst.valid  = pop;
  assign dst.field  = fieldMem[rdPtr];
  assign dst.value  = valueMem[rdPtr];
  assign src.credit = pop;

  always_ff @(posedge clk) begin
    if (push) begin
      fieldMem[wrPtr] <= src.field;
      valueMem[wrPtr] <= src.value;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wrPtr     <= '0;
      rdPtr     <= '0;
      count     <= '0;
      dstCredit <= 1'b1;
    end else begin
      if (push) begin
        wrPtr <= incPtr(wrPtr);
      end
      if (pop) begin
        rdPtr <= incPtr(rdPtr);
      end
      count     <= count + CountW'(push) - CountW'(pop);
      dstCredit <= (dstCredit & ~pop) | dst.credit;
    end
  end

endmodule

// ==== hw/displayWriter.sv ====
`timescale 1ns/10ps

module displayWriter (
  input  logic            clk,
  input  logic            rst,
  fieldIf.receiver        src,
  input  logic            dispReady,
  output rtcPkg::busAddrT dispAddr,
  output rtcPkg::dataT    dispData,
  output logic            dispValid
);
  import rtcPkg::*;

  logic done;
  logic creditQ;

  assign done       = dispValid & dispReady;
  assign src.credit = creditQ;

  always_ff @(posedge clk) begin
    if (rst) begin
      dispValid <= 1'b0;
      creditQ   <= 1'b0;
    end else begin
      creditQ <= done;
      if (src.valid) begin
        dispValid <= 1'b1;
      end else if (done) begin
        dispValid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (src.valid) begin
      dispAddr <= DispAddr[src.field];
      dispData <= src.value;
    end
  end

endmodule

// ==== hw/rtcController.sv ====
`timescale 1ns/10ps

module rtcController #(
  parameter int DebounceCycles = 16,
  parameter int FifoDepth      = 4
) (
  input  logic            clk,
  input  logic            rst,
  input  rtcPkg::dataT    busRdData,
  input  logic            busRdValid,
  input  logic            up,
  input  logic            down,
  input  logic            left,
  input  logic            right,
  input  logic            setTime,
  input  logic            setDate,
  input  logic            setTimer,
  input  logic            dispReady,
  output rtcPkg::busAddrT busAddr,
  output logic            busRdEn,
  output logic            busWrEn,
  output rtcPkg::dataT    busWrData,
  output rtcPkg::busAddrT dispAddr,
  output rtcPkg::dataT    dispData,
  output logic            dispValid,
  output rtcPkg::cursorT  cursorPos
);
  import rtcPkg::*;

  logic       upPress;
  logic       downPress;
  logic       leftPress;
  logic       rightPress;
  editGroupT  editGroup;
  logic       editEnable;
  fieldArrayT fields;
  logic       editValid;
  fieldIdxT   editField;
  dataT       editValue;

  fieldIf seqToFifo ();
  fieldIf fifoToDisp ();

  // ******************************
  // Buttons
  // ******************************
  buttonDebouncer #(.DebounceCycles(DebounceCycles)) upDebouncer_inst (
    .clk    (clk),
    .rst    (rst),
    .button (up),
    .press  (upPress)
  );

  buttonDebouncer #(.DebounceCycles(DebounceCycles)) downDebouncer_inst (
    .clk    (clk),
    .rst    (rst),
    .button (down),
    .press  (downPress)
  );

  buttonDebouncer #(.DebounceCycles(DebounceCycles)) leftDebouncer_inst (
    .clk    (clk),
    .rst    (rst),
    .button (left),
    .press  (leftPress)
  );

  buttonDebouncer #(.DebounceCycles(DebounceCycles)) rightDebouncer_inst (
    .clk    (clk),
    .rst    (rst),
    .button (right),
    .press  (rightPress)
  );

  fieldEditor fieldEditor_inst (
    .clk        (clk),
    .rst        (rst),
    .editGroup  (editGroup),
    .editEnable (editEnable),
    .fields     (fields),
    .upPress    (upPress),
    .downPress  (downPress),
    .leftPress  (leftPress),
    .rightPress (rightPress),
    .editValid  (editValid),
    .editField  (editField),
    .editValue  (editValue),
    .cursorPos  (cursorPos)
  );

  // ******************************
  // Producer, buffer, consumer
  // ******************************
  rtcSequencer #(.FifoDepth(FifoDepth)) rtcSequencer_inst (
    .clk        (clk),
    .rst        (rst),
    .busRdData  (busRdData),
    .busRdValid (busRdValid),
    .setTime    (setTime),
    .setDate    (setDate),
    .setTimer   (setTimer),
    .editValid  (editValid),
    .editField  (editField),
    .editValue  (editValue),
    .busAddr    (busAddr),
    .busRdEn    (busRdEn),
    .busWrEn    (busWrEn),
    .busWrData  (busWrData),
    .editGroup  (editGroup),
    .editEnable (editEnable),
    .fields     (fields),
    .upd        (seqToFifo.sender)
  );

  updateFifo #(.FifoDepth(FifoDepth)) updateFifo_inst (
    .clk (clk),
    .rst (rst),
    .src (seqToFifo.receiver),
    .dst (fifoToDisp.sender)
  );

  displayWriter displayWriter_inst (
    .clk       (clk),
    .rst       (rst),
    .src       (fifoToDisp.receiver),
    .dispReady (dispReady),
    .dispAddr  (dispAddr),
    .dispData  (dispData),
    .dispValid (dispValid)
  );

endmodule

// ==== sim/tbTasks.svh ====
// ******************************
// Reporting
// ******************************
task automatic startTest(input string name);
  curTest    = name;
  testErrors = 0;
endtask

task automatic endTest();
  testsRun++;
  if (testErrors != 0) begin
    testsFailed++;
  end
  $display("%s finished with %0d errors", curTest, testErrors);
endtask

task automatic reportMismatch(input string what, input int expected, input int actual);
  $display("error %s: %s expected 0x%0h actual 0x%0h", curTest, what, expected, actual);
  testErrors++;
  errorCount++;
endtask

task automatic reportProblem(input string what);
  $display("%s: %s", curTest, what);
  testErrors++;
  errorCount++;
endtask

// Hands the end of the run to the abort watcher and parks this process
task automatic abortRun(input string what);
  $display("%s: gave up waiting for %s", curTest, what);
  testErrors++;
  errorCount++;
  aborted = 1'b1;
  forever @(posedge clk);
endtask

// ******************************
// Waits with their own timeouts
// ******************************
task automatic waitDisplayCount(input int count);
  int n;
  n = 0;
  while (dispAddrQ.size() < count && n < WaitLimit) begin
    @(negedge clk);
    n++;
  end
  if (dispAddrQ.size() < count) abortRun("display writes");
endtask

task automatic waitWriteCount(input int count);
  int n;
  n = 0;
  while (wrAddrQ.size() < count && n < WaitLimit) begin
    @(negedge clk);
    n++;
  end
  if (wrAddrQ.size() < count) abortRun("RTC writes");
endtask

task automatic waitReadCount(input int count);
  int n;
  n = 0;
  while (rdAddrQ.size() < count && n < WaitLimit) begin
    @(negedge clk);
    n++;
  end
  if (rdAddrQ.size() < count) abortRun("RTC reads");
endtask

task automatic waitCursor(input logic [3:0] value);
  int n;
  n = 0;
  while (cursorPos != value && n < WaitLimit) begin
    @(negedge clk);
    n++;
  end
  if (cursorPos != value) abortRun("the cursor to reach its position");
endtask

// Drained once dispValid stays low for a few cycles
task automatic waitDisplayIdle();
  int n;
  int quiet;
  n     = 0;
  quiet = 0;
  while (quiet < IdleCycles && n < WaitLimit) begin
    @(negedge clk);
    quiet = dispValid ? 0 : quiet + 1;
    n++;
  end
  if (quiet < IdleCycles) abortRun("the display to go idle");
endtask

// ******************************
// Buttons
// ******************************
task automatic setButton(input int which, input logic level);
  case (which)
    UpBtn:    up    <= level;
    DownBtn:  down  <= level;
    LeftBtn:  left  <= level;
    default:  right <= level;
  endcase
endtask

// Hold and release are both long enough to pass the debouncer
task automatic pressButton(input int which);
  @(posedge clk);
  setButton(which, 1'b1);
  repeat (HoldCycles) @(posedge clk);
  setButton(which, 1'b0);
  repeat (HoldCycles) @(posedge clk);
  @(negedge clk);
endtask

// ******************************
// Directed tests
// ******************************
task automatic testReadout();
  int i;
  startTest("readout");
  waitDisplayCount(NumRegs);
  for (i = 0; i < NumRegs; i++) begin
    if (rdAddrQ[i] != ExpRtcAddr[i]) begin
      reportMismatch($sformatf("read %0d address", i), ExpRtcAddr[i], rdAddrQ[i]);
    end
    if (dispAddrQ[i] != ExpDispAddr[i]) begin
      reportMismatch($sformatf("display %0d address", i), ExpDispAddr[i], dispAddrQ[i]);
    end
    if (dispDataQ[i] != StartValue[i]) begin
      reportMismatch($sformatf("display %0d data", i), StartValue[i], dispDataQ[i]);
    end
  end
  endTest();
endtask

task automatic testBackPressure();
  int doneAtStart;
  int doneAtMid;
  int doneAtRelease;
  int i;
  startTest("backPressure");
  @(posedge clk);
  dispReady <= 1'b0;
  @(negedge clk);
  doneAtStart = rdDoneCnt;
  repeat (100) @(negedge clk);
  doneAtMid = rdDoneCnt;
  repeat (100) @(negedge clk);
  // FIFO and display hold FifoDepth+1 and one more read waits for a credit
  if (rdDoneCnt - doneAtStart > FifoDepth + 2) begin
    reportProblem($sformatf("%0d reads completed during the stall, limit %0d",
                            rdDoneCnt - doneAtStart, FifoDepth + 2));
  end
  if (rdDoneCnt != doneAtMid) begin
    reportProblem("reads kept running while the display was stalled");
  end
  @(posedge clk);
  dispReady <= 1'b1;
  @(negedge clk);
  doneAtRelease = rdDoneCnt;
  waitDisplayCount(doneAtRelease);
  for (i = 0; i < dispAddrQ.size(); i++) begin
    if (dispAddrQ[i] != ExpDispAddr[i % NumRegs]) begin
      reportMismatch($sformatf("display %0d address", i), ExpDispAddr[i % NumRegs],
                     dispAddrQ[i]);
    end
    if (dispDataQ[i] != StartValue[i % NumRegs]) begin
      reportMismatch($sformatf("display %0d data", i), StartValue[i % NumRegs],
                     dispDataQ[i]);
    end
  end
  endTest();
endtask

task automatic testEditTime();
  int idx;
  startTest("editTime");
  @(posedge clk);
  setTime <= 1'b1;
  // Time group starts on hours
  waitCursor(4'd3);
  waitDisplayIdle();
  pressButton(RightBtn);
  if (cursorPos != 4'd4) begin
    reportMismatch("cursor position", 4, cursorPos);
  end
  idx = dispAddrQ.size();
  pressButton(UpBtn);
  waitDisplayCount(idx + 1);
  expBank[minField] = StartValue[minField] + 8'd1;
  if (dispAddrQ[idx] != ExpDispAddr[minField]) begin
    reportMismatch("display address", ExpDispAddr[minField], dispAddrQ[idx]);
  end
  if (dispDataQ[idx] != expBank[minField]) begin
    reportMismatch("minutes", expBank[minField], dispDataQ[idx]);
  end
  endTest();
endtask

task automatic testWrapLimits();
  int idx;
  int wrIdx;
  startTest("wrapLimits");
  pressButton(LeftBtn);
  if (cursorPos != 4'd3) begin
    reportMismatch("cursor position", 3, cursorPos);
  end
  idx = dispAddrQ.size();
  pressButton(UpBtn);
  waitDisplayCount(idx + 1);
  expBank[hourField] = 8'd0;
  if (dispAddrQ[idx] != ExpDispAddr[hourField]) begin
    reportMismatch("display address", ExpDispAddr[hourField], dispAddrQ[idx]);
  end
  if (dispDataQ[idx] != expBank[hourField]) begin
    reportMismatch("hours after 23", expBank[hourField], dispDataQ[idx]);
  end

  // Leave time mode and enter date mode right after the write-back
  wrIdx = wrAddrQ.size();
  @(posedge clk);
  setTime <= 1'b0;
  waitWriteCount(wrIdx + 1);
  @(posedge clk);
  setDate <= 1'b1;
  idx = dispAddrQ.size();
  waitWriteCount(wrIdx + NumRegs);
  waitDisplayCount(idx + 1);
  if (dispAddrQ[idx] != ExpDispAddr[secField]) begin
    reportMismatch("first display after write-back", ExpDispAddr[secField], dispAddrQ[idx]);
  end
  waitDisplayIdle();
  idx = dispAddrQ.size();
  pressButton(DownBtn);
  waitDisplayCount(idx + 1);
  expBank[dayField] = 8'd31;
  if (dispAddrQ[idx] != ExpDispAddr[dayField]) begin
    reportMismatch("display address", ExpDispAddr[dayField], dispAddrQ[idx]);
  end
  if (dispDataQ[idx] != expBank[dayField]) begin
    reportMismatch("day below 1", expBank[dayField], dispDataQ[idx]);
  end
  endTest();
endtask

task automatic testWriteBack();
  int wrIdx;
  int rdIdx;
  int i;
  startTest("writeBack");
  wrIdx = wrAddrQ.size();
  rdIdx = rdAddrQ.size();
  @(posedge clk);
  setDate <= 1'b0;
  waitWriteCount(wrIdx + NumRegs);
  for (i = 0; i < NumRegs; i++) begin
    if (wrAddrQ[wrIdx + i] != ExpRtcAddr[i]) begin
      reportMismatch($sformatf("write %0d address", i), ExpRtcAddr[i], wrAddrQ[wrIdx + i]);
    end
    if (wrDataQ[wrIdx + i] != expBank[i]) begin
      reportMismatch($sformatf("write %0d data", i), expBank[i], wrDataQ[wrIdx + i]);
    end
    if (wrCycleQ[wrIdx + i] != wrCycleQ[wrIdx] + i) begin
      reportProblem($sformatf("write %0d did not follow the previous write directly", i));
    end
  end
  waitReadCount(rdIdx + 1);
  if (rdAddrQ[rdIdx] != ExpRtcAddr[secField]) begin
    reportMismatch("first read after write-back", ExpRtcAddr[secField], rdAddrQ[rdIdx]);
  end
  endTest();
endtask

// ==== sim/tbRtcController.sv ====
`timescale 1ns/10ps

module tbRtcController;
  import rtcPkg::*;

  localparam int DebounceCycles = 4;
  localparam int FifoDepth      = 4;
  localparam int NumRegs        = 9;
  localparam int WaitLimit      = 2000;
  localparam int IdleCycles     = 6;
  // Synchronizer delay and debounce count plus margin
  localparam int HoldCycles     = DebounceCycles + 8;

  localparam int UpBtn    = 0;
  localparam int DownBtn  = 1;
  localparam int LeftBtn  = 2;
  localparam int RightBtn = 3;

  // Per-field expectations in read order
  localparam logic [7:0] ExpRtcAddr [NumRegs] = '{
    8'h21, 8'h22, 8'h23, 8'h24, 8'h25, 8'h26, 8'h41, 8'h42, 8'h43
  };
  localparam logic [7:0] ExpDispAddr [NumRegs] = '{
    8'h07, 8'h06, 8'h05, 8'h08, 8'h09, 8'h0A, 8'h0D, 8'h0C, 8'h0B
  };
  localparam logic [7:0] StartValue [NumRegs] = '{
    8'd42, 8'd23, 8'd23, 8'd1, 8'd7, 8'd24, 8'd5, 8'd30, 8'd2
  };

  logic    clk;
  logic    rst;
  dataT    busRdData;
  logic    busRdValid;
  logic    up;
  logic    down;
  logic    left;
  logic    right;
  logic    setTime;
  logic    setDate;
  logic    setTimer;
  logic    dispReady;
  busAddrT busAddr;
  logic    busRdEn;
  logic    busWrEn;
  dataT    busWrData;
  busAddrT dispAddr;
  dataT    dispData;
  logic    dispValid;
  cursorT  cursorPos;

  // RTC model and display sink
  logic [7:0] rtcRegs [256];
  logic [7:0] rdAddrQ [$];
  logic [7:0] wrAddrQ [$];
  logic [7:0] wrDataQ [$];
  int         wrCycleQ [$];
  logic [7:0] dispAddrQ [$];
  logic [7:0] dispDataQ [$];
  logic       rdPending;
  logic [7:0] rdAddr;
  int         rdDelay;
  int         rdDoneCnt;
  int         cycle;

  // Test bookkeeping
  string       curTest;
  int          testErrors;
  int          errorCount;
  int          testsRun;
  int          testsFailed;
  logic        aborted;
  logic [7:0]  expBank [NumRegs];
  int unsigned seed;

  rtcController #(
    .DebounceCycles (DebounceCycles),
    .FifoDepth      (FifoDepth)
  ) rtcController_inst (
    .clk        (clk),
    .rst        (rst),
    .busRdData  (busRdData),
    .busRdValid (busRdValid),
    .up         (up),
    .down       (down),
    .left       (left),
    .right      (right),
    .setTime    (setTime),
    .setDate    (setDate),
    .setTimer   (setTimer),
    .dispReady  (dispReady),
    .busAddr    (busAddr),
    .busRdEn    (busRdEn),
    .busWrEn    (busWrEn),
    .busWrData  (busWrData),
    .dispAddr   (dispAddr),
    .dispData   (dispData),
    .dispValid  (dispValid),
    .cursorPos  (cursorPos)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ******************************
  // RTC bus model
  // ******************************
  initial begin
    seed = $urandom(3231);
    forever begin
      @(posedge clk);
      busRdValid <= 1'b0;
      if (rst) begin
        rdPending <= 1'b0;
        rdDoneCnt <= 0;
        cycle     <= 0;
      end else begin
        cycle <= cycle + 1;
        if (rdPending) begin
          if (rdDelay <= 1) begin
            busRdValid <= 1'b1;
            busRdData  <= rtcRegs[rdAddr];
            rdPending  <= 1'b0;
            rdDoneCnt  <= rdDoneCnt + 1;
          end else begin
            rdDelay <= rdDelay - 1;
          end
        end else if (busRdEn) begin
          // Latency of 1 to 5 cycles
          rdPending <= 1'b1;
          rdAddr    <= busAddr;
          rdDelay   <= $urandom_range(5, 1);
          rdAddrQ.push_back(busAddr);
        end
        if (busWrEn) begin
          rtcRegs[busAddr] <= busWrData;
          wrAddrQ.push_back(busAddr);
          wrDataQ.push_back(busWrData);
          wrCycleQ.push_back(cycle);
        end
      end
    end
  end

  // Display sink logs each completed write
  always @(posedge clk) begin
    if (!rst && dispValid && dispReady) begin
      dispAddrQ.push_back(dispAddr);
      dispDataQ.push_back(dispData);
    end
  end

  `include "tbTasks.svh"

  // Ends the run when a wait gives up
  initial begin
    wait (aborted);
    $display("Checks failed");
    $finish;
  end

  initial begin
    int a;
    rst        = 1'b1;
    busRdData  = '0;
    busRdValid = 1'b0;
    up         = 1'b0;
    down       = 1'b0;
    left       = 1'b0;
    right      = 1'b0;
    setTime    = 1'b0;
    setDate    = 1'b0;
    setTimer   = 1'b0;
    dispReady  = 1'b1;
    aborted     = 1'b0;
    errorCount  = 0;
    testsRun    = 0;
    testsFailed = 0;
    for (a = 0; a < 256; a++) begin
      rtcRegs[a] = 8'(a) ^ 8'h5A;
    end
    for (a = 0; a < NumRegs; a++) begin
      rtcRegs[ExpRtcAddr[a]] = StartValue[a];
      expBank[a] = StartValue[a];
    end
    repeat (16) @(posedge clk);
    rst <= 1'b0;

    testReadout();
    testBackPressure();
    testEditTime();
    testWrapLimits();
    testWriteBack();

    $display("%0d tests run, %0d with errors, %0d errors in total",
             testsRun, testsFailed, errorCount);
    if (errorCount == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
+incdir+sim
hw/rtcPkg.sv
hw/fieldIf.sv
hw/buttonDebouncer.sv
hw/fieldEditor.sv
hw/rtcSequencer.sv
hw/updateFifo.sv
hw/displayWriter.sv
hw/rtcController.sv
sim/tbRtcController.sv

// ==== Bender.yml ====
package:
  name: rtc_controller

sources:
  - files:
      - hw/rtcPkg.sv
      - hw/fieldIf.sv
      - hw/buttonDebouncer.sv
      - hw/fieldEditor.sv
      - hw/rtcSequencer.sv
      - hw/updateFifo.sv
      - hw/displayWriter.sv
      - hw/rtcController.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tbRtcController.sv
